/* Makefile */
# Verilator build and run of the history search testbench

VERILATOR ?= verilator
TOP       ?= tb_oflow_history
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
PATTERNS  ?= oflow_patterns.hex
VFLAGS    ?= --binary -j 0
TRACE     ?=

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) $(TRACE) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(PATTERNS)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* oflow_frame_writer.sv */
// frame writer
// puts each incoming line into the ring slot of the current frame
// and remembers the last offset written in every slot
module oflow_frame_writer (
	input  logic                                clk,
	input  logic                                reset_N,
	input  logic [oflow_pkg::FRAME_NUM_WIDTH-1:0] frame_num,  // current frame
	input  logic                                wr_valid,
	input  logic                                wr_last,    // with final line of frame
	input  oflow_pkg::line_t                    wr_line,
	output logic                                wr_en,
	output logic [oflow_pkg::ADDR_WIDTH-1:0]    wr_addr,
	output oflow_pkg::line_t                    wr_data,
	output logic [oflow_pkg::OFFSET_WIDTH-1:0]  end_pointers [oflow_pkg::HIST_SLOTS]
);
	import oflow_pkg::*;

	logic [OFFSET_WIDTH-1:0] line_cnt;  // offset of the next line in this frame
	logic [SLOT_WIDTH-1:0]   wr_slot;

	assign wr_slot = slot_of(frame_num);

	// --------------------
	// line counter
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			line_cnt <= '0;
		end else if (wr_valid) begin
			if (wr_last)
				line_cnt <= '0;  // next frame starts at offset 0
			else
				line_cnt <= line_cnt + 1'b1;
		end
	end

	// --------------------
	// end pointers, one per slot
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			for (int i = 0; i < HIST_SLOTS; i++)
				end_pointers[i] <= '0;
		end else if (wr_valid && wr_last) begin
			end_pointers[wr_slot] <= line_cnt;  // last offset, not a count
		end
	end

	// write port, memory takes it on this edge
	assign wr_en   = wr_valid;
	assign wr_addr = {wr_slot, line_cnt};  // slot * 16 + offset
	assign wr_data = wr_line;

endmodule

/* oflow_fsm_read.sv */
// history read FSM
// walks frame_num-1 back to frame_num-N, and inside each frame
// every stored line up to its end pointer, one line in flight
module oflow_fsm_read (
	input  logic                                 clk,
	input  logic                                 reset_N,
	input  logic [oflow_pkg::FRAME_NUM_WIDTH-1:0] frame_num,
	input  logic [oflow_pkg::HIST_WIDTH-1:0]     num_of_history_frames,
	input  logic [oflow_pkg::OFFSET_WIDTH-1:0]   end_pointers [oflow_pkg::HIST_SLOTS],
	input  logic                                 start_read,   // ignored when busy
	input  logic                                 line_done,    // from sad stage
	output logic                                 rd_en,
	output logic [oflow_pkg::ADDR_WIDTH-1:0]     rd_addr,
	output logic [oflow_pkg::FRAME_NUM_WIDTH-1:0] cand_frame,
	output logic [oflow_pkg::OFFSET_WIDTH-1:0]   cand_offset,
	output logic                                 search_start,
	output logic                                 done_read
);
	import oflow_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FRAME,   // pick next history frame or finish
		ST_ISSUE,   // one rd_en
		ST_WAIT     // line in flight
	} state_t;

	state_t                   state;
	state_t                   next_state;
	logic [HIST_WIDTH-1:0]    hist_cnt;     // frames already searched
	logic [OFFSET_WIDTH-1:0]  offset_cnt;
	logic [FRAME_NUM_WIDTH-1:0] rd_frame;   // frame being walked
	logic [SLOT_WIDTH-1:0]    rd_slot;
	logic                     more_frames;
	logic                     last_line;

	assign rd_slot     = slot_of(rd_frame);
	assign more_frames = hist_cnt < num_of_history_frames;
	assign last_line   = offset_cnt == end_pointers[rd_slot];

	// --------------------
	// state register
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE:  if (start_read) next_state = ST_FRAME;
			ST_FRAME: next_state = more_frames ? ST_ISSUE : ST_IDLE;
			ST_ISSUE: next_state = ST_WAIT;
			ST_WAIT: begin
				if (line_done)
					next_state = last_line ? ST_FRAME : ST_ISSUE;  // next rd_en right away
			end
			default:  next_state = ST_IDLE;
		endcase
	end

	// --------------------
	// counters
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			hist_cnt   <= '0;
			offset_cnt <= '0;
		end else begin
			if (state == ST_IDLE)
				hist_cnt <= '0;
			else if (state == ST_WAIT && line_done && last_line)
				hist_cnt <= hist_cnt + 1'b1;  // frame finished

			if (state == ST_FRAME)
				offset_cnt <= '0;
			else if (state == ST_WAIT && line_done && !last_line)
				offset_cnt <= offset_cnt + 1'b1;
		end
	end

	// frame to read, held through the offset walk
	always_ff @(posedge clk) begin
		if (state == ST_FRAME && more_frames)
			rd_frame <= frame_num - FRAME_NUM_WIDTH'(hist_cnt) - FRAME_NUM_WIDTH'(1);
	end

	// candidate tag travels alongside the read
	always_ff @(posedge clk) begin
		if (rd_en) begin
			cand_frame  <= rd_frame;
			cand_offset <= offset_cnt;
		end
	end

	assign rd_en        = state == ST_ISSUE;
	assign rd_addr      = {rd_slot, offset_cnt};
	assign search_start = (state == ST_IDLE) && start_read;
	assign done_read    = (state == ST_FRAME) && !more_frames;  // also N == 0

endmodule

/* oflow_history_buffer.sv */
// history buffer
// line memory for five frame slots of sixteen lines each
// one write port, one registered read port
module oflow_history_buffer (
	input  logic                             clk,
	input  logic                             reset_N,
	input  logic                             wr_en,
	input  logic [oflow_pkg::ADDR_WIDTH-1:0] wr_addr,
	input  oflow_pkg::line_t                 wr_data,
	input  logic                             rd_en,
	input  logic [oflow_pkg::ADDR_WIDTH-1:0] rd_addr,
	output oflow_pkg::line_t                 rd_data,   // one cycle after rd_en
	output logic                             rd_valid
);
	import oflow_pkg::*;

	line_t mem [BUF_DEPTH];

	// --------------------
	// memory array
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		if (rd_en)
			rd_data <= mem[rd_addr];  // old data on same-address collision
	end

	// valid follows rd_en by one cycle
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_en;
	end

endmodule

/* oflow_history_top.sv */
// optical-flow history search, top level
// frame writer, history buffer, read FSM and SAD stage
module oflow_history_top (
	input  logic                                 clk,
	input  logic                                 reset_N,
	input  logic [oflow_pkg::FRAME_NUM_WIDTH-1:0] frame_num,
	input  logic                                 wr_valid,
	input  oflow_pkg::line_t                     wr_line,
	input  logic                                 wr_last,
	input  logic [oflow_pkg::HIST_WIDTH-1:0]     num_of_history_frames,
	input  oflow_pkg::line_t                     ref_line,
	input  logic                                 start_read,
	output logic                                 result_valid,
	output logic [oflow_pkg::FRAME_NUM_WIDTH-1:0] best_frame,
	output logic [oflow_pkg::OFFSET_WIDTH-1:0]   best_offset,
	output logic [oflow_pkg::SAD_WIDTH-1:0]      best_sad
);
	import oflow_pkg::*;

	// --------------------
	// writer side
	logic                   wr_en;
	logic [ADDR_WIDTH-1:0]  wr_addr;
	line_t                  wr_data;
	logic [OFFSET_WIDTH-1:0] end_pointers [HIST_SLOTS];

	// read side
	logic                   rd_en;
	logic [ADDR_WIDTH-1:0]  rd_addr;
	line_t                  rd_data;
	logic                   rd_valid;
	logic [FRAME_NUM_WIDTH-1:0] cand_frame;
	logic [OFFSET_WIDTH-1:0] cand_offset;
	logic                   search_start;
	logic                   done_read;
	logic                   line_done;   // paces the read FSM

	oflow_frame_writer u_writer (
		.clk          (clk),
		.reset_N      (reset_N),
		.frame_num    (frame_num),
		.wr_valid     (wr_valid),
		.wr_last      (wr_last),
		.wr_line      (wr_line),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.end_pointers (end_pointers)
	);

	oflow_history_buffer u_buffer (
		.clk      (clk),
		.reset_N  (reset_N),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.rd_en    (rd_en),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.rd_valid (rd_valid)
	);

	oflow_fsm_read u_fsm_read (
		.clk                   (clk),
		.reset_N               (reset_N),
		.frame_num             (frame_num),
		.num_of_history_frames (num_of_history_frames),
		.end_pointers          (end_pointers),
		.start_read            (start_read),
		.line_done             (line_done),
		.rd_en                 (rd_en),
		.rd_addr               (rd_addr),
		.cand_frame            (cand_frame),
		.cand_offset           (cand_offset),
		.search_start          (search_start),
		.done_read             (done_read)
	);

	oflow_line_sad u_line_sad (
		.clk          (clk),
		.reset_N      (reset_N),
		.ref_line     (ref_line),
		.rd_data      (rd_data),
		.rd_valid     (rd_valid),
		.cand_frame   (cand_frame),
		.cand_offset  (cand_offset),
		.search_start (search_start),
		.done_read    (done_read),
		.line_done    (line_done),
		.result_valid (result_valid),
		.best_frame   (best_frame),
		.best_offset  (best_offset),
		.best_sad     (best_sad)
	);

endmodule

/* oflow_line_sad.sv */
// line SAD stage
// sums |cand - ref| one pixel per cycle, then compares against
// the running best; publishes the best on done_read
module oflow_line_sad (
	input  logic                                 clk,
	input  logic                                 reset_N,
	input  oflow_pkg::line_t                     ref_line,
	input  oflow_pkg::line_t                     rd_data,
	input  logic                                 rd_valid,
	input  logic [oflow_pkg::FRAME_NUM_WIDTH-1:0] cand_frame,
	input  logic [oflow_pkg::OFFSET_WIDTH-1:0]   cand_offset,
	input  logic                                 search_start,
	input  logic                                 done_read,
	output logic                                 line_done,
	output logic                                 result_valid,
	output logic [oflow_pkg::FRAME_NUM_WIDTH-1:0] best_frame,
	output logic [oflow_pkg::OFFSET_WIDTH-1:0]   best_offset,
	output logic [oflow_pkg::SAD_WIDTH-1:0]      best_sad
);
	import oflow_pkg::*;

	line_t                      cand_line;   // captured candidate
	logic [PIX_IDX_WIDTH-1:0]   pix_idx;
	logic                       acc_busy;
	logic [SAD_WIDTH-1:0]       acc;
	logic [PIXEL_WIDTH-1:0]     pix_a;
	logic [PIXEL_WIDTH-1:0]     pix_b;
	logic [PIXEL_WIDTH-1:0]     abs_diff;
	logic [SAD_WIDTH-1:0]       run_sad;     // running best of this search
	logic [FRAME_NUM_WIDTH-1:0] run_frame;
	logic [OFFSET_WIDTH-1:0]    run_offset;

	// --------------------
	// per-pixel difference
	always_comb begin
		pix_a    = cand_line[pix_idx];
		pix_b    = ref_line[pix_idx];
		abs_diff = (pix_a > pix_b) ? pix_a - pix_b : pix_b - pix_a;
	end

	always_ff @(posedge clk) begin
		if (rd_valid)
			cand_line <= rd_data;
	end

	// accumulate over LINE_PIXELS cycles, then one compare cycle
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			acc_busy  <= 1'b0;
			pix_idx   <= '0;
			acc       <= '0;
			line_done <= 1'b0;
		end else begin
			line_done <= 1'b0;
			if (rd_valid) begin
				acc_busy <= 1'b1;
				pix_idx  <= '0;
				acc      <= '0;
			end else if (acc_busy) begin
				acc     <= acc + SAD_WIDTH'(abs_diff);
				pix_idx <= pix_idx + 1'b1;
				if (pix_idx == PIX_IDX_WIDTH'(LINE_PIXELS - 1)) begin
					acc_busy  <= 1'b0;
					line_done <= 1'b1;  // compare cycle
				end
			end
		end
	end

	// --------------------
	// running best, strict less keeps the earliest
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			run_sad    <= '0;
			run_frame  <= '0;
			run_offset <= '0;
		end else if (search_start) begin
			run_sad    <= '1;  // 3FF, nothing seen yet
			run_frame  <= '0;
			run_offset <= '0;
		end else if (line_done && acc < run_sad) begin
			run_sad    <= acc;
			run_frame  <= cand_frame;
			run_offset <= cand_offset;
		end
	end

	// result registers
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			result_valid <= 1'b0;
			best_frame   <= '0;
			best_offset  <= '0;
			best_sad     <= '0;
		end else begin
			result_valid <= done_read;
			if (done_read) begin
				best_frame  <= run_frame;
				best_offset <= run_offset;
				best_sad    <= run_sad;
			end
		end
	end

endmodule

/* oflow_patterns.hex */
// kind(1 write, 2 search)_frame_last or hist_line_exp frame_exp offset or copies-1_exp sad
// a write record puts copies-1+1 equal lines, last flag goes with the final copy
// frame 0, four lines, then an exact match search
1_00_0_10101010_00_0_000
1_00_0_20202020_00_0_000
1_00_0_30303030_00_0_000
1_00_1_40404040_00_0_000
2_01_1_30303030_00_2_000
// frame 1, sixteen lines, best line at offset 15
1_01_0_80808080_00_E_000
1_01_1_55555555_00_0_000
2_02_2_56565656_01_F_004
// frame 2, a single line
1_02_1_60606060_00_0_000
2_03_2_58585858_01_F_00C
// frames 3 to 6, slot 1 reused with seven lines
1_03_0_70707070_00_5_000
1_03_1_73737373_00_0_000
1_04_1_90909090_00_1_000
1_05_1_A0A0A0A0_00_2_000
1_06_1_50505050_00_6_000
// four history frames across the ring wrap
2_07_4_55555555_06_0_014
2_07_4_72727272_03_6_004
// tie between frames 5 and 4
2_07_4_98989898_05_0_020
// empty search
2_07_0_00000000_00_0_3FF
// writes between back-to-back searches
1_07_0_11223344_00_0_000
1_07_1_44332211_00_0_000
2_08_1_40302010_07_1_00A
1_08_0_01020304_00_0_000
1_08_1_05050505_00_1_000
2_09_2_03030303_08_0_004
2_09_3_12233445_07_0_004

/* oflow_pkg.sv */
// optical-flow history search, shared definitions
// widths, the line type and the ring slot helper
package oflow_pkg;

	// --------------------
	// frame numbering
	localparam int FRAME_NUM_WIDTH = 8;  // frame serial number, wraps at 256
	localparam int HIST_SLOTS      = 5;  // ring of stored frames
	localparam int HIST_WIDTH      = 3;  // num_of_history_frames, 0 to 4 legal
	localparam int SLOT_WIDTH      = 3;  // slot index 0..4

	// --------------------
	// line storage
	localparam int OFFSET_WIDTH    = 4;  // up to 16 lines per frame
	localparam int ADDR_WIDTH      = 7;  // slot * 16 + offset
	localparam int BUF_DEPTH       = HIST_SLOTS << OFFSET_WIDTH;  // 80 lines

	// --------------------
	// pixels and sad
	localparam int PIXEL_WIDTH     = 8;
	localparam int LINE_PIXELS     = 4;
	localparam int PIX_IDX_WIDTH   = 2;  // walks the pixels of one line
	localparam int SAD_WIDTH       = 10; // 4 * 255 fits

	// one line, pixel 0 in the low byte
	typedef logic [LINE_PIXELS-1:0][PIXEL_WIDTH-1:0] line_t;

	// ring slot of a frame, frame number mod HIST_SLOTS
	function automatic logic [SLOT_WIDTH-1:0] slot_of(
		input logic [FRAME_NUM_WIDTH-1:0] frame
	);
		return SLOT_WIDTH'(frame % HIST_SLOTS);
	endfunction

endpackage

/* sim.f */
oflow_pkg.sv
oflow_frame_writer.sv
oflow_history_buffer.sv
oflow_fsm_read.sv
oflow_line_sad.sv
oflow_history_top.sv
tb_oflow_history.sv

/* tb_oflow_history.sv */
// testbench for the optical-flow history search
// replays line writes and searches from the pattern file and
// checks best frame, best offset and best SAD of every search
module tb_oflow_history;
	import oflow_pkg::*;

	localparam int MAX_RECS       = 64;
	localparam int CYCLES_PER_REC = 200;  // watchdog budget per record

	logic                       clk;
	logic                       reset_N;
	logic [FRAME_NUM_WIDTH-1:0] frame_num;
	logic                       wr_valid;
	line_t                      wr_line;
	logic                       wr_last;
	logic [HIST_WIDTH-1:0]      num_of_history_frames;
	line_t                      ref_line;
	logic                       start_read;
	logic                       result_valid;
	logic [FRAME_NUM_WIDTH-1:0] best_frame;
	logic [OFFSET_WIDTH-1:0]    best_offset;
	logic [SAD_WIDTH-1:0]       best_sad;

	// kind, frame, last or hist, line, exp frame, exp offset or copies, exp sad
	logic [71:0] recs [MAX_RECS];
	int          n_recs      = 0;
	int          result_cnt  = 0;  // result_valid pulses seen
	int          exp_results = 0;  // searches started

	oflow_history_top u_dut (
		.clk                   (clk),
		.reset_N               (reset_N),
		.frame_num             (frame_num),
		.wr_valid              (wr_valid),
		.wr_line               (wr_line),
		.wr_last               (wr_last),
		.num_of_history_frames (num_of_history_frames),
		.ref_line              (ref_line),
		.start_read            (start_read),
		.result_valid          (result_valid),
		.best_frame            (best_frame),
		.best_offset           (best_offset),
		.best_sad              (best_sad)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// mid-cycle sample, away from the edge
	always @(negedge clk) begin
		if (result_valid)
			result_cnt++;
	end

	// --------------------
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic step_clock();
		@(posedge clk);
		#1;  // drive and sample just after the edge
	endtask

	task automatic compare_output(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		assert (actual == expected)
		else stop_on_error($sformatf("** Error: %s expected %0h, got %0h",
			name, expected, actual));
	endtask

	task automatic write_lines(input logic [71:0] rec);
		int copies;
		int gap;
		copies = int'(rec[15:12]) + 1;
		for (int i = 0; i < copies; i++) begin
			gap = int'($urandom % 4);  // idle cycles before the line
			repeat (gap) step_clock();
			frame_num = rec[67:60];
			wr_line   = rec[55:24];
			wr_valid  = 1'b1;
			wr_last   = rec[56] && (i == copies - 1);  // only on the final copy
			step_clock();
			wr_valid  = 1'b0;
			wr_last   = 1'b0;
		end
	endtask

	task automatic run_search(input logic [71:0] rec);
		frame_num             = rec[67:60];  // held for the whole search
		num_of_history_frames = rec[58:56];
		ref_line              = rec[55:24];
		start_read            = 1'b1;
		exp_results++;
		step_clock();
		start_read = 1'b0;
		while (!result_valid)
			step_clock();  // watchdog catches a lost result
		compare_output("best_frame", 32'(best_frame), 32'(rec[23:16]));
		compare_output("best_offset", 32'(best_offset), 32'(rec[15:12]));
		compare_output("best_sad", 32'(best_sad), 32'(rec[11:0]));
		repeat (2) step_clock();  // a second pulse would be counted by now
		assert (result_cnt == exp_results)
		else stop_on_error($sformatf("result_valid pulsed %0d times over %0d searches",
			result_cnt, exp_results));
	endtask

	// --------------------
	// main sequence
	initial begin
		logic [71:0] rec;
		int          count;
		void'($urandom(2202));
		reset_N               = 1'b0;
		frame_num             = '0;
		wr_valid              = 1'b0;
		wr_line               = '0;
		wr_last               = 1'b0;
		num_of_history_frames = '0;
		ref_line              = '0;
		start_read            = 1'b0;
		foreach (recs[i])
			recs[i] = '0;  // kind 0 marks the end
		$readmemh("oflow_patterns.hex", recs);
		count = 0;
		while (count < MAX_RECS && recs[count][71:68] != 4'h0)
			count++;
		n_recs = count;
		assert (n_recs > 0)
		else stop_on_error("the pattern file holds no records");

		repeat (2) @(posedge clk);
		#1 reset_N = 1'b1;
		compare_output("result_valid", 32'(result_valid), 32'h0);
		compare_output("best_sad", 32'(best_sad), 32'h0);

		for (int idx = 0; idx < n_recs; idx++) begin
			rec = recs[idx];
			case (rec[71:68])
				4'h1:    write_lines(rec);
				4'h2:    run_search(rec);
				default: stop_on_error($sformatf("record %0d has an unknown kind", idx));
			endcase
		end
		$display("Test OK");
		$finish;
	end

	// watchdog, budget grows with the record count
	initial begin
		@(posedge reset_N);
		repeat (n_recs * CYCLES_PER_REC) @(posedge clk);
		stop_on_error($sformatf("timeout, the run did not finish within %0d cycles",
			n_recs * CYCLES_PER_REC));
	end

endmodule
